// File: project.f
rtl/perf_pkg.sv
rtl/perf_regs.sv
rtl/axi_wr_gen.sv
rtl/perf_stats.sv
rtl/axi_wr_sink.sv
rtl/axi_perf_top.sv
tests/axi_perf_asserts.sv
tests/tb_axi_perf.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_perf -f project.f -o sim_tb_axi_perf

result=$(./obj_dir/sim_tb_axi_perf +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$result"

printf '%s\n' "$result" | grep -qx "Everything OK"

// File: tests/tb_axi_perf.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_perf
  import perf_pkg::*;
();

  logic                clk;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_ack;
  int                  errors;
  int                  faults_at_start;
  int                  tests;
  int                  tests_failed;
  int                  limit_cycles;
  perf_cfg_t           rnd_cfg [5];

  axi_perf_top axi_perf_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack)
  );

  bind axi_perf_top axi_perf_asserts axi_perf_asserts_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .aw      (aw),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .w       (w),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .b_valid (b_valid),
    .b_ready (b_ready)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ==========================================================================
  // wishbone access and reference model
  // ==========================================================================
  function automatic int fault_count();
    return errors + axi_perf_top_i.axi_perf_asserts_i.assert_fails;
  endfunction

  task automatic wb_access(input logic we, input reg_addr_e adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 8);
    assert (wb_ack && waited == 2) else begin      // request seen one edge after drive.
      $display("ack for access to %s did not come one cycle after the request", adr.name());
      errors++;
    end
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input reg_addr_e adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic check_reg(input reg_addr_e adr, input logic [31:0] exp);
    logic [31:0] got;
    wb_access(1'b0, adr, 32'h0, got);
    assert (got == exp) else begin
      $display("[FAIL] %s expected %08h got %08h", adr.name(), exp, got);
      errors++;
    end
  endtask

  task automatic start_run(input perf_cfg_t c);
    wb_write(REG_BASE, 32'(c.base));
    wb_write(REG_BURSTS, 32'(c.bursts));
    wb_write(REG_LEN, 32'(c.len));
    wb_write(REG_SEED, c.seed);
    wb_write(REG_CTRL, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    do begin
      wb_access(1'b0, REG_STATUS, 32'h0, st);
    end while (!st[1]);
  endtask

  // xor of data and beat address over the whole run.
  function automatic logic [31:0] model_checksum(input perf_cfg_t c);
    logic [31:0]       sum;
    logic [31:0]       data;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] baddr;
    sum  = '0;
    data = c.seed;
    for (int i = 0; i < int'(c.bursts); i++) begin
      addr = c.base + ADDR_W'(i * (int'(c.len) + 1) * 4);
      for (int j = 0; j <= int'(c.len); j++) begin
        baddr = addr + ADDR_W'(4 * j);
        sum   = sum ^ data ^ {{(DATA_W-ADDR_W){1'b0}}, baddr};
        data  = data + 32'd1;
      end
    end
    return sum;
  endfunction

  task automatic check_results(input perf_cfg_t c);
    check_reg(REG_CHECKSUM, model_checksum(c));
    check_reg(REG_BEATS, 32'(int'(c.bursts) * (int'(c.len) + 1)));
    check_reg(REG_DONE_BURSTS, 32'(c.bursts));
    check_reg(REG_ERRORS, 32'h0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (fault_count() == faults_at_start) begin
      $display("test %0d %s: passed", tests, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED", tests, name);
    end
    faults_at_start = fault_count();
  endtask

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, a run never finished", limit_cycles);
    $display("Something failed");
    $finish;
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    perf_cfg_t   c;
    logic [31:0] cyc_val;
    logic [31:0] beat_val;
    int          total;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    errors   = 0;
    tests    = 0;
    tests_failed    = 0;
    faults_at_start = 0;
    void'($urandom(67));
    total = 4 + 128 + 32 + 4;                      // beats of the fixed runs.
    for (int n = 0; n < 5; n++) begin
      rnd_cfg[n].base   = ADDR_W'($urandom & 32'hffff_fffc);
      rnd_cfg[n].bursts = 16'($urandom % 8 + 1);
      rnd_cfg[n].len    = 8'($urandom % 16);
      rnd_cfg[n].seed   = $urandom;
      total += int'(rnd_cfg[n].bursts) * (int'(rnd_cfg[n].len) + 1);
    end
    limit_cycles = 200 * total + 5000;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    for (int a = 0; a <= 10; a++) begin
      check_reg(reg_addr_e'(a), 32'h0);
    end
    end_test("reset values");

    c = '{base: 28'h0001000, bursts: 16'd1, len: 8'd3, seed: 32'h1234_5678};
    start_run(c);
    wait_done();
    check_results(c);
    end_test("single burst");

    for (int n = 0; n < 5; n++) begin
      start_run(rnd_cfg[n]);
      wait_done();
      check_results(rnd_cfg[n]);
    end
    end_test("random runs");

    c = '{base: 28'h0200000, bursts: 16'd8, len: 8'd15, seed: 32'ha5a5_0000};
    start_run(c);
    check_reg(REG_STATUS, 32'h1);
    wb_write(REG_BURSTS, 32'h1);
    wb_write(REG_LEN, 32'h0);
    wb_write(REG_CTRL, 32'h1);                     // lands while busy.
    wait_done();
    check_results(c);
    check_reg(REG_STATUS, 32'h2);
    end_test("start while busy");

    c = '{base: 28'hffffff0, bursts: 16'd4, len: 8'd7, seed: 32'hffff_fff0};
    start_run(c);
    check_reg(REG_STATUS, 32'h1);
    wait_done();
    check_reg(REG_STATUS, 32'h2);
    wb_access(1'b0, REG_CYCLES, 32'h0, cyc_val);
    wb_access(1'b0, REG_BEATS, 32'h0, beat_val);
    assert (cyc_val >= beat_val) else begin
      $display("[FAIL] REG_CYCLES expected at least %08h got %08h", beat_val, cyc_val);
      errors++;
    end
    c.bursts = 16'd2;
    c.len    = 8'd1;
    start_run(c);
    check_reg(REG_STATUS, 32'h1);                  // done cleared by the new start.
    wait_done();
    check_results(c);
    end_test("status and cycles");

    $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests, tests - tests_failed, tests_failed, errors,
             axi_perf_top_i.axi_perf_asserts_i.assert_fails);
    if (fault_count() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/axi_perf_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module axi_perf_asserts
  import perf_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    wb_cyc,
  input logic    wb_stb,
  input logic    wb_ack,
  input axi_aw_t aw,
  input logic    aw_valid,
  input logic    aw_ready,
  input axi_w_t  w,
  input logic    w_valid,
  input logic    w_ready,
  input logic    b_valid,
  input logic    b_ready
);

  int               assert_fails = 0;
  logic [OUT_W-1:0] pending;                       // bursts awaiting a response.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending + OUT_W'(aw_valid && aw_ready) - OUT_W'(b_valid && b_ready);
    end
  end

  // ==========================================================================
  // wishbone and AXI handshakes
  // ==========================================================================
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_cyc && wb_stb && !wb_ack |=> wb_ack)
    else begin
      assert_fails++;
      $error("wishbone ack did not follow the request by one cycle");
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else begin
      assert_fails++;
      $error("wishbone ack lasted more than one cycle");
    end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else begin
      assert_fails++;
      $error("aw_valid dropped or aw changed before the handshake");
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else begin
      assert_fails++;
      $error("w_valid dropped or w changed before the handshake");
    end

  aw_limit: assert property (@(posedge clk) disable iff (!rst_n)
    pending == OUT_W'(MAX_OUT) |-> !aw_valid)
    else begin
      assert_fails++;
      $error("aw_valid raised with the maximum number of bursts outstanding");
    end

  // four byte beats, incrementing bursts and full strobes.
  fixed_fields: assert property (@(posedge clk) disable iff (!rst_n)
    (!aw_valid || (aw.size == 3'd2 && aw.burst == 2'b01)) && (!w_valid || w.strb == '1))
    else begin
      assert_fails++;
      $error("aw size, aw burst type or w strobes differ from the fixed values");
    end

endmodule

`default_nettype wire

// File: rtl/axi_perf_top.sv
`timescale 1ns/1ns
`default_nettype none

module axi_perf_top
  import perf_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_w,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack
);

  perf_cfg_t  cfg;
  perf_stat_t stat;
  sink_stat_t sink_stat;
  logic       start;
  logic       busy;

  // ==========================================================================
  // AXI4 write channels between the generator and the on-chip target
  // ==========================================================================
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  logic    aw_valid;
  logic    aw_ready;
  logic    w_valid;
  logic    w_ready;
  logic    b_valid;
  logic    b_ready;

  perf_regs perf_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .busy     (busy),
    .stat     (stat),
    .sink_stat(sink_stat),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .cfg      (cfg),
    .start    (start)
  );

  axi_wr_gen axi_wr_gen_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .start   (start),
    .aw_ready(aw_ready),
    .w_ready (w_ready),
    .b       (b),
    .b_valid (b_valid),
    .aw      (aw),
    .aw_valid(aw_valid),
    .w       (w),
    .w_valid (w_valid),
    .b_ready (b_ready),
    .busy    (busy)
  );

  perf_stats perf_stats_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .busy   (busy),
    .w_valid(w_valid),
    .w_ready(w_ready),
    .b_valid(b_valid),
    .b_ready(b_ready),
    .stat   (stat)
  );

  axi_wr_sink axi_wr_sink_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .run_clear(start),                             // stats restart with each run.
    .aw       (aw),
    .aw_valid (aw_valid),
    .w        (w),
    .w_valid  (w_valid),
    .b_ready  (b_ready),
    .aw_ready (aw_ready),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .sink_stat(sink_stat)
  );

endmodule

`default_nettype wire

// File: rtl/axi_wr_sink.sv
`timescale 1ns/1ns
`default_nettype none

module axi_wr_sink
  import perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run_clear,
  input  axi_aw_t    aw,
  input  logic       aw_valid,
  input  axi_w_t     w,
  input  logic       w_valid,
  input  logic       b_ready,
  output logic       aw_ready,
  output logic       w_ready,
  output axi_b_t     b,
  output logic       b_valid,
  output sink_stat_t sink_stat
);

  logic [ADDR_W-1:0] q_addr [2];
  logic [ID_W-1:0]   q_id   [2];
  logic [7:0]        q_len  [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        q_cnt;
  logic [7:0]        beat_idx;
  logic [ADDR_W-1:0] beat_addr;
  logic [15:0]       lfsr;
  logic              stall;
  logic              exp_last;
  logic              aw_hs;
  logic              w_hs;
  logic              pop;
  logic [ID_W-1:0]   b_id;

  assign stall     = lfsr[0] && lfsr[5];           // roughly one cycle in four.
  assign aw_ready  = q_cnt != 2'd2;
  assign w_ready   = q_cnt != 2'd0 && !stall && !(b_valid && !b_ready);
  assign aw_hs     = aw_valid && aw_ready;
  assign w_hs      = w_valid && w_ready;
  assign beat_addr = q_addr[rd_ptr] + ADDR_W'({beat_idx, 2'b00});
  assign exp_last  = beat_idx == q_len[rd_ptr];
  assign pop       = w_hs && exp_last;
  assign b.id      = b_id;
  assign b.resp    = AXI_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      q_cnt     <= '0;
      beat_idx  <= '0;
      b_valid   <= 1'b0;
      lfsr      <= 16'hace1;
      sink_stat <= '0;
    end else begin
      lfsr  <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      q_cnt <= q_cnt + 2'(aw_hs) - 2'(pop);
      if (aw_hs) begin
        wr_ptr <= !wr_ptr;
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
      if (w_hs) begin
        beat_idx <= pop ? 8'd0 : beat_idx + 8'd1;
      end
      if (pop) begin
        rd_ptr  <= !rd_ptr;
        b_valid <= 1'b1;                           // answer follows the last beat.
      end
      if (run_clear) begin
        sink_stat <= '0;
      end else if (w_hs) begin
        sink_stat.checksum <= sink_stat.checksum ^ w.data ^ DATA_W'(beat_addr);
        if (w.last != exp_last) begin
          sink_stat.errors <= sink_stat.errors + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      q_addr[wr_ptr] <= aw.addr;
      q_id[wr_ptr]   <= aw.id;
      q_len[wr_ptr]  <= aw.len;
    end
    if (pop) begin
      b_id <= q_id[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/perf_stats.sv
`timescale 1ns/1ns
`default_nettype none

module perf_stats
  import perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       busy,
  input  logic       w_valid,
  input  logic       w_ready,
  input  logic       b_valid,
  input  logic       b_ready,
  output perf_stat_t stat
);

  logic [31:0] cycles;
  logic [31:0] beats;
  logic [15:0] done_bursts;

  assign stat.cycles      = cycles;
  assign stat.beats       = beats;
  assign stat.done_bursts = done_bursts;

  // counters hold their values once the run ends.
  always_ff @(posedge clk) begin
    if (!rst_n || start) begin
      cycles      <= '0;
      beats       <= '0;
      done_bursts <= '0;
    end else begin
      if (busy) begin
        cycles <= cycles + 32'd1;
      end
      if (w_valid && w_ready) begin
        beats <= beats + 32'd1;
      end
      if (b_valid && b_ready) begin
        done_bursts <= done_bursts + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_wr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module axi_wr_gen
  import perf_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  perf_cfg_t cfg,
  input  logic      start,
  input  logic      aw_ready,
  input  logic      w_ready,
  input  axi_b_t    b,
  input  logic      b_valid,
  output axi_aw_t   aw,
  output logic      aw_valid,
  output axi_w_t    w,
  output logic      w_valid,
  output logic      b_ready,
  output logic      busy
);

  gen_state_e        state;
  perf_cfg_t         cfg_q;
  logic [15:0]       aw_cnt;
  logic [15:0]       aw_cnt_next;
  logic [ADDR_W-1:0] aw_addr;
  logic [ADDR_W-1:0] stride;
  logic [15:0]       w_cnt;
  logic [7:0]        w_beat;
  logic [DATA_W-1:0] w_data;
  logic [OUT_W-1:0]  out_cnt;
  logic [OUT_W-1:0]  out_next;
  logic [ID_W-1:0]   oldest_id;
  logic              aw_hs;
  logic              w_hs;
  logic              b_hs;
  logic              all_sent;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;

  // responses come back in order, so the oldest outstanding id is known.
  assign oldest_id = ID_W'(aw_cnt - 16'(out_cnt));
  assign b_hs      = b_valid && b_ready && b.id == oldest_id;

  assign aw_cnt_next = aw_cnt + 16'(aw_hs);
  assign out_next    = out_cnt + OUT_W'(aw_hs) - OUT_W'(b_hs);
  assign stride      = ADDR_W'({cfg_q.len, 2'b00}) + ADDR_W'(STRB_W);
  assign all_sent    = aw_cnt == cfg_q.bursts && w_cnt == cfg_q.bursts;

  assign aw.addr  = aw_addr;
  assign aw.id    = aw_cnt[ID_W-1:0];
  assign aw.len   = cfg_q.len;
  assign aw.size  = AXI_SIZE;
  assign aw.burst = AXI_INCR;
  assign w.data   = w_data;
  assign w.strb   = '1;
  assign w.last   = w_beat == cfg_q.len;
  assign b_ready  = 1'b1;
  assign busy     = state != IDLE;

  // ==========================================================================
  // run control
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      aw_cnt   <= '0;
      w_cnt    <= '0;
      w_beat   <= '0;
      out_cnt  <= '0;
    end else begin
      out_cnt <= out_next;
      case (state)
        IDLE: begin
          if (start) begin
            state    <= RUN;
            aw_cnt   <= '0;
            w_cnt    <= '0;
            w_beat   <= '0;
            aw_valid <= cfg.bursts != 16'd0;
            w_valid  <= cfg.bursts != 16'd0;
          end
        end
        RUN: begin
          aw_cnt   <= aw_cnt_next;
          aw_valid <= aw_cnt_next != cfg_q.bursts && out_next < MAX_OUT;
          if (w_hs) begin
            if (w.last) begin
              w_beat  <= '0;
              w_cnt   <= w_cnt + 16'd1;
              w_valid <= w_cnt + 16'd1 != cfg_q.bursts;
            end else begin
              w_beat <= w_beat + 8'd1;
            end
          end
          if (all_sent) begin
            state <= (out_next == '0) ? IDLE : DRAIN;   // busy drops right after last b.
          end
        end
        DRAIN: begin
          if (out_next == '0) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ==========================================================================
  // address and data pattern
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      cfg_q   <= cfg;
      aw_addr <= cfg.base;
      w_data  <= cfg.seed;
    end else begin
      if (aw_hs) begin
        aw_addr <= aw_addr + stride;
      end
      if (w_hs) begin
        w_data <= w_data + DATA_W'(1);             // seed plus run beat index.
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/perf_regs.sv
`timescale 1ns/1ns
`default_nettype none

module perf_regs
  import perf_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_w,
  input  logic                busy,
  input  perf_stat_t          stat,
  input  sink_stat_t          sink_stat,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack,
  output perf_cfg_t           cfg,
  output logic                start
);

  logic                req;
  logic                busy_q;
  logic                done;
  logic [WB_DAT_W-1:0] rdata;
  reg_addr_e           addr;

  assign req  = wb_cyc && wb_stb && !wb_ack;      // first cycle of a transfer.
  assign addr = reg_addr_e'(wb_adr);

  always_comb begin
    rdata = '0;
    case (addr)
      REG_STATUS:      rdata[1:0]        = {done, busy};
      REG_BASE:        rdata[ADDR_W-1:0] = cfg.base;
      REG_BURSTS:      rdata[15:0]       = cfg.bursts;
      REG_LEN:         rdata[7:0]        = cfg.len;
      REG_SEED:        rdata[DATA_W-1:0] = cfg.seed;
      REG_CYCLES:      rdata             = stat.cycles;
      REG_BEATS:       rdata             = stat.beats;
      REG_CHECKSUM:    rdata[DATA_W-1:0] = sink_stat.checksum;
      REG_ERRORS:      rdata[15:0]       = sink_stat.errors;
      REG_DONE_BURSTS: rdata[15:0]       = stat.done_bursts;
      default:         rdata             = '0;   // ctrl reads back as zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      cfg    <= '0;
      busy_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      wb_ack <= req;
      start  <= req && wb_we && addr == REG_CTRL && wb_dat_w[0] && !busy;
      busy_q <= busy;
      if (start) begin
        done <= 1'b0;
      end else if (busy_q && !busy) begin
        done <= 1'b1;                              // run just finished.
      end
      if (req && wb_we) begin
        case (addr)
          REG_BASE:   cfg.base   <= wb_dat_w[ADDR_W-1:0];
          REG_BURSTS: cfg.bursts <= wb_dat_w[15:0];
          REG_LEN:    cfg.len    <= wb_dat_w[7:0];
          REG_SEED:   cfg.seed   <= wb_dat_w[DATA_W-1:0];
          default:    cfg        <= cfg;
        endcase
      end
    end
  end

  // read data is captured with the request and shows up with ack.
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: rtl/perf_pkg.sv
`default_nettype none

package perf_pkg;

  // ==========================================================================
  // widths and limits
  // ==========================================================================
  localparam int ADDR_W   = 28;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;            // also the byte stride per beat.
  localparam int ID_W     = 4;
  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;
  localparam int MAX_OUT  = 2;                     // bursts awaiting a response.
  localparam int OUT_W    = $clog2(MAX_OUT + 1);

  localparam logic [2:0] AXI_SIZE = 3'($clog2(STRB_W));
  localparam logic [1:0] AXI_INCR = 2'b01;
  localparam logic [1:0] AXI_OKAY = 2'b00;

  // ==========================================================================
  // register map and generator states
  // ==========================================================================
  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL        = 4'd0,                        // bit 0 starts a run.
    REG_STATUS      = 4'd1,                        // bit 0 busy, bit 1 done.
    REG_BASE        = 4'd2,
    REG_BURSTS      = 4'd3,
    REG_LEN         = 4'd4,                        // beats minus one.
    REG_SEED        = 4'd5,
    REG_CYCLES      = 4'd6,
    REG_BEATS       = 4'd7,
    REG_CHECKSUM    = 4'd8,
    REG_ERRORS      = 4'd9,
    REG_DONE_BURSTS = 4'd10
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } gen_state_e;

  // ==========================================================================
  // channel and status bundles
  // ==========================================================================
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [15:0]       bursts;
    logic [7:0]        len;
    logic [DATA_W-1:0] seed;
  } perf_cfg_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

  typedef struct packed {
    logic [31:0] cycles;
    logic [31:0] beats;
    logic [15:0] done_bursts;
  } perf_stat_t;

  typedef struct packed {
    logic [DATA_W-1:0] checksum;
    logic [15:0]       errors;
  } sink_stat_t;

endpackage

`default_nettype wire
